// File: build.f
+incdir+.
mips_pkg.sv
alu.sv
regFile.sv
mipsController.sv
mipsDatapath.sv
mips.sv
mips_checker.sv
mips_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mips testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module mipsTb -o mipsSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/mipsSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

if grep -q "^Test passed$" sim.log; then
   exit 0
fi

echo "pass message not found in sim.log"
exit 1

// File: mips_tb.sv
`include "mips_defines.svh"

module mipsTb;

   import mips_pkg::*;

   localparam int PERIOD       = 4;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_INSTR    = 300;
   localparam int MAX_CYCLES   = 8;  // longest instruction, lb
   localparam int TIMEOUT      = NUM_INSTR * MAX_CYCLES * PERIOD + (RESET_CYCLES + 2) * PERIOD;

   logic                   clk = 1'b0;
   logic                   reset;
   logic [`DATA_WIDTH-1:0] memData;
   logic [`DATA_WIDTH-1:0] adr;
   logic [`DATA_WIDTH-1:0] writeData;
   logic                   memRead;
   logic                   memWrite;

   logic [`DATA_WIDTH-1:0] mem   [0:`MEM_BYTES-1];
   logic [`DATA_WIDTH-1:0] image [0:`MEM_BYTES-1]; // program loaded at reset
   logic [`DATA_WIDTH-1:0] expAdr[$];
   logic [`DATA_WIDTH-1:0] expData[$];
   logic                   expWrite[$];
   int                     expIdx = 0;
   integer                 seed = 84;

   mips i_dut
   (
      .clk       (clk),
      .reset     (reset),
      .memData   (memData),
      .adr       (adr),
      .writeData (writeData),
      .memRead   (memRead),
      .memWrite  (memWrite)
   );

   always #(PERIOD/2) clk = ~clk;

   // ----------------------------------------------------------------------
   // memory model, combinational read
   // ----------------------------------------------------------------------
   assign memData = mem[adr];

   always @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < `MEM_BYTES; i++)
            mem[i] <= image[i];
      end
      else if (memWrite)
         mem[adr] <= writeData;
   end

   // ----------------------------------------------------------------------
   // random program and reference model
   // ----------------------------------------------------------------------
   task automatic makeInstr(output logic [31:0] w);
      int                kind;
      logic [2:0]        rs;
      logic [2:0]        rt;
      logic [2:0]        rd;
      logic [15:0]       imm;
      kind = int'($unsigned($random(seed)) % 9);
      rs   = 3'($random(seed));
      rt   = 3'($random(seed));
      rd   = 3'($random(seed));
      imm  = 16'($random(seed));
      case (kind)
         0: w = {OP_LB, 2'b00, rs, 2'b00, rt, imm};
         1: w = {OP_SB, 2'b00, rs, 2'b00, rt, imm};
         2: w = {OP_RTYPE, 2'b00, rs, 2'b00, rt, 2'b00, rd, 5'b0, F_ADD};
         3: w = {OP_RTYPE, 2'b00, rs, 2'b00, rt, 2'b00, rd, 5'b0, F_SUB};
         4: w = {OP_RTYPE, 2'b00, rs, 2'b00, rt, 2'b00, rd, 5'b0, F_AND};
         5: w = {OP_RTYPE, 2'b00, rs, 2'b00, rt, 2'b00, rd, 5'b0, F_OR};
         6: w = {OP_RTYPE, 2'b00, rs, 2'b00, rt, 2'b00, rd, 5'b0, F_SLT};
         7: w = {OP_BEQ, 2'b00, rs, 2'b00, rt, imm};
         default: w = {OP_J, 20'b0, imm[5:0]}; // 6-bit target
      endcase
   endtask

   task automatic fillProgram();
      logic [31:0] w;
      for (int a = 0; a < `MEM_BYTES; a += 4)
      begin
         makeInstr(w);
         image[a]     = w[31:24]; // big-endian
         image[a + 1] = w[23:16];
         image[a + 2] = w[15:8];
         image[a + 3] = w[7:0];
      end
   endtask

   task automatic pushAccess(input logic [7:0] a, input logic [7:0] d, input logic wr);
      expAdr.push_back(a);
      expData.push_back(d);
      expWrite.push_back(wr);
   endtask

   task automatic buildExpected();
      logic [7:0]  mm [0:`MEM_BYTES-1];
      logic [7:0]  regs [0:7];
      logic [7:0]  pc;
      logic [7:0]  a;
      logic [7:0]  x;
      logic [7:0]  y;
      logic [7:0]  diff;
      logic [31:0] w;
      for (int i = 0; i < `MEM_BYTES; i++)
         mm[i] = image[i];
      for (int i = 0; i < 8; i++)
         regs[i] = 8'h00;
      pc = 8'h00;
      for (int n = 0; n < NUM_INSTR; n++)
      begin
         w = {mm[pc], mm[8'(pc + 1)], mm[8'(pc + 2)], mm[8'(pc + 3)]};
         for (int k = 0; k < 4; k++)
            pushAccess(8'(pc + k), 8'h00, 1'b0);
         pc = pc + 8'd4;
         x  = regs[w[23:21]];  // rs
         y  = regs[w[18:16]];  // rt
         case (opcodeT'(w[31:26]))
            OP_LB:
            begin
               a = x + w[7:0];
               pushAccess(a, 8'h00, 1'b0);
               regs[w[18:16]] = mm[a];
            end
            OP_SB:
            begin
               a = x + w[7:0];
               pushAccess(a, y, 1'b1);
               mm[a] = y;
            end
            OP_RTYPE:
            begin
               diff = x - y;
               case (functT'(w[5:0]))
                  F_ADD:   regs[w[13:11]] = x + y;
                  F_SUB:   regs[w[13:11]] = diff;
                  F_OR:    regs[w[13:11]] = x | y;
                  F_SLT:   regs[w[13:11]] = {7'b0, diff[7]};
                  default: regs[w[13:11]] = x & y;
               endcase
            end
            OP_BEQ:
            begin
               if (x == y)
                  pc = pc + {w[5:0], 2'b00};
            end
            OP_J:    pc = {w[5:0], 2'b00};
            default: ;  // unknown opcode does nothing
         endcase
         regs[0] = 8'h00;
      end
   endtask

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------
   task automatic failRun(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic checkRead(input logic [`DATA_WIDTH-1:0] got, input logic [`DATA_WIDTH-1:0] exp);
      if (got !== exp)
         failRun($sformatf("mismatch adr on read %0d: got %h, expected %h", expIdx, got, exp));
   endtask

   task automatic checkWrite(input logic [`DATA_WIDTH-1:0] gotAdr,
                             input logic [`DATA_WIDTH-1:0] gotData,
                             input logic [`DATA_WIDTH-1:0] exAdr,
                             input logic [`DATA_WIDTH-1:0] exData);
      if (gotAdr !== exAdr)
         failRun($sformatf("mismatch adr on write %0d: got %h, expected %h",
                           expIdx, gotAdr, exAdr));
      if (gotData !== exData)
         failRun($sformatf("mismatch writeData on write %0d: got %h, expected %h",
                           expIdx, gotData, exData));
   endtask

   // monitor samples mid-cycle, away from the edge
   always @(negedge clk)
   begin
      if (!reset && (memRead || memWrite))
      begin
         if (expIdx >= expAdr.size())
            failRun("memory access after the last expected access");
         else if (memWrite !== expWrite[expIdx])
            failRun($sformatf("access %0d has the wrong kind, write expected to be %0b",
                              expIdx, expWrite[expIdx]));
         else if (memWrite)
            checkWrite(adr, writeData, expAdr[expIdx], expData[expIdx]);
         else
            checkRead(adr, expAdr[expIdx]);
         expIdx <= expIdx + 1;
      end
   end

   // watchdog
   initial
   begin
      #(TIMEOUT);
      $display("processor stalled, expected accesses did not finish in time");
      $display("Test failed");
      $fatal(1);
   end

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial
   begin
      reset = 1'b1;
      fillProgram();
      buildExpected();
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      while (expIdx < expAdr.size())
         @(posedge clk);
      if (expIdx == expAdr.size())
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: mips_checker.sv
module mipsChecker
(
   input logic            clk,
   input logic            reset,
   input logic            memRead,
   input logic            memWrite,
   input mips_pkg::stateT state
);

   import mips_pkg::*;

   // ----------------------------------------------------------------------
   // memory strobe rules
   // ----------------------------------------------------------------------
   strobesExclusive: assert property (@(posedge clk) disable iff (reset)
      !(memRead && memWrite))
      else $error("memRead and memWrite high together");

   writeOneCycle: assert property (@(posedge clk) disable iff (reset)
      memWrite |=> !memWrite)
      else $error("memWrite held longer than one cycle");

   // write only in SBWR
   writeState: assert property (@(posedge clk) disable iff (reset)
      memWrite == (state == SBWR))
      else $error("memWrite outside SBWR or missing in SBWR");

   readState: assert property (@(posedge clk) disable iff (reset)
      memRead == (state inside {FETCH1, FETCH2, FETCH3, FETCH4, LBRD}))
      else $error("memRead does not match the state"); // fetch and lb read only

endmodule

bind mipsController mipsChecker i_checker
(
   .clk      (clk),
   .reset    (reset),
   .memRead  (memRead),
   .memWrite (memWrite),
   .state    (state)
);

// File: mips.sv
`include "mips_defines.svh"

module mips
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`DATA_WIDTH-1:0] memData,
   output logic [`DATA_WIDTH-1:0] adr,
   output logic [`DATA_WIDTH-1:0] writeData,
   output logic                   memRead,
   output logic                   memWrite
);

   import mips_pkg::*;

   opcodeT   op;
   functT    funct;
   logic [3:0] irWrite;
   logic     pcWrite;
   logic     pcWriteCond;
   logic     aluSrcA;
   aluSrcBT  aluSrcB;
   aluOpT    aluOp;
   pcSourceT pcSource;
   logic     iOrD;
   logic     memToReg;
   logic     regWrite;
   logic     regDst;

   mipsController i_controller
   (
      .clk         (clk),
      .reset       (reset),
      .op          (op),
      .funct       (funct),
      .memRead     (memRead),
      .memWrite    (memWrite),
      .irWrite     (irWrite),
      .pcWrite     (pcWrite),
      .pcWriteCond (pcWriteCond),
      .aluSrcA     (aluSrcA),
      .aluSrcB     (aluSrcB),
      .aluOp       (aluOp),
      .pcSource    (pcSource),
      .iOrD        (iOrD),
      .memToReg    (memToReg),
      .regWrite    (regWrite),
      .regDst      (regDst)
   );

   mipsDatapath i_datapath
   (
      .clk         (clk),
      .reset       (reset),
      .memData     (memData),
      .irWrite     (irWrite),
      .pcWrite     (pcWrite),
      .pcWriteCond (pcWriteCond),
      .aluSrcA     (aluSrcA),
      .aluSrcB     (aluSrcB),
      .aluOp       (aluOp),
      .pcSource    (pcSource),
      .iOrD        (iOrD),
      .memToReg    (memToReg),
      .regWrite    (regWrite),
      .regDst      (regDst),
      .op          (op),
      .funct       (funct),
      .adr         (adr),
      .writeData   (writeData)
   );

endmodule

// File: mipsDatapath.sv
`include "mips_defines.svh"

module mipsDatapath
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`DATA_WIDTH-1:0] memData,
   input  logic [3:0]             irWrite,
   input  logic                   pcWrite,
   input  logic                   pcWriteCond,
   input  logic                   aluSrcA,
   input  mips_pkg::aluSrcBT      aluSrcB,
   input  mips_pkg::aluOpT        aluOp,
   input  mips_pkg::pcSourceT     pcSource,
   input  logic                   iOrD,
   input  logic                   memToReg,
   input  logic                   regWrite,
   input  logic                   regDst,
   output mips_pkg::opcodeT       op,
   output mips_pkg::functT        funct,
   output logic [`DATA_WIDTH-1:0] adr,
   output logic [`DATA_WIDTH-1:0] writeData
);

   import mips_pkg::*;

   logic [`INSTR_WIDTH-1:0] instr;
   logic [`DATA_WIDTH-1:0]  pc;
   logic [`DATA_WIDTH-1:0]  nextPc;
   logic [`DATA_WIDTH-1:0]  mdr;
   logic [`DATA_WIDTH-1:0]  aReg;
   logic [`DATA_WIDTH-1:0]  aluOut;
   logic [`DATA_WIDTH-1:0]  rd1;
   logic [`DATA_WIDTH-1:0]  rd2;
   logic [`DATA_WIDTH-1:0]  wd;
   logic [`DATA_WIDTH-1:0]  srcA;
   logic [`DATA_WIDTH-1:0]  srcB;
   logic [`DATA_WIDTH-1:0]  aluResult;
   logic [`DATA_WIDTH-1:0]  immX4;
   logic [`REG_BITS-1:0]    wa;
   logic                    zero;
   logic                    pcEn;

   // ----------------------------------------------------------------------
   // instruction fields
   // ----------------------------------------------------------------------
   assign op     = opcodeT'(instr[`INSTR_WIDTH-1 -: `OPCODE_BITS]);
   assign funct  = functT'(instr[`FUNCT_BITS-1:0]);
   assign immX4  = {instr[`DATA_WIDTH-3:0], 2'b00}; // also the jump target
   assign wa     = regDst ? instr[11 +: `REG_BITS] : instr[16 +: `REG_BITS];

   // instruction register, one byte per fetch cycle
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 4; i++)
      begin
         if (irWrite[i])
            instr[i*8 +: 8] <= memData;
      end
   end

   // ----------------------------------------------------------------------
   // program counter
   // ----------------------------------------------------------------------
   assign pcEn = pcWrite | (pcWriteCond & zero);

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '0;
      else if (pcEn)
         pc <= nextPc;
   end

   always_comb
   begin
      case (pcSource)
         PCS_ALU:    nextPc = aluResult;
         PCS_ALUOUT: nextPc = aluOut;   // branch target from decode
         PCS_JUMP:   nextPc = immX4;
         default:    nextPc = '0;
      endcase
   end

   // holding registers, loaded every cycle
   always_ff @(posedge clk)
   begin
      mdr       <= memData;
      aReg      <= rd1;
      writeData <= rd2;
      aluOut    <= aluResult;
   end

   // ----------------------------------------------------------------------
   // operand and address muxes
   // ----------------------------------------------------------------------
   assign adr  = iOrD ? aluOut : pc;
   assign srcA = aluSrcA ? aReg : pc;
   assign wd   = memToReg ? mdr : aluOut;

   always_comb
   begin
      case (aluSrcB)
         SRCB_REG:   srcB = writeData;
         SRCB_ONE:   srcB = `DATA_WIDTH'(1);
         SRCB_IMM:   srcB = instr[`DATA_WIDTH-1:0];
         default:    srcB = immX4;
      endcase
   end

   regFile i_regFile
   (
      .clk      (clk),
      .reset    (reset),
      .regWrite (regWrite),
      .ra1      (instr[21 +: `REG_BITS]), // rs
      .ra2      (instr[16 +: `REG_BITS]), // rt
      .wa       (wa),
      .wd       (wd),
      .rd1      (rd1),
      .rd2      (rd2)
   );

   alu i_alu
   (
      .a      (srcA),
      .b      (srcB),
      .aluOp  (aluOp),
      .result (aluResult),
      .zero   (zero)
   );

endmodule

// File: mipsController.sv
module mipsController
(
   input  logic               clk,
   input  logic               reset,
   input  mips_pkg::opcodeT   op,
   input  mips_pkg::functT    funct,
   output logic               memRead,
   output logic               memWrite,
   output logic [3:0]         irWrite,
   output logic               pcWrite,
   output logic               pcWriteCond,
   output logic               aluSrcA,
   output mips_pkg::aluSrcBT  aluSrcB,
   output mips_pkg::aluOpT    aluOp,
   output mips_pkg::pcSourceT pcSource,
   output logic               iOrD,
   output logic               memToReg,
   output logic               regWrite,
   output logic               regDst
);

   import mips_pkg::*;

   stateT state;
   stateT nextState;

   // ----------------------------------------------------------------------
   // state register and next state
   // ----------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         state <= FETCH1;
      else
         state <= nextState;
   end

   always_comb
   begin
      nextState = FETCH1; // back to fetch unless told otherwise
      case (state)
         FETCH1:  nextState = FETCH2;
         FETCH2:  nextState = FETCH3;
         FETCH3:  nextState = FETCH4;
         FETCH4:  nextState = DECODE;
         DECODE:
         begin
            case (op)
               OP_LB, OP_SB: nextState = MEMADR;
               OP_RTYPE:     nextState = RTYPEEX;
               OP_BEQ:       nextState = BEQEX;
               OP_J:         nextState = JEX;
               default:      nextState = FETCH1; // unknown opcode is a no-op
            endcase
         end
         MEMADR:  nextState = (op == OP_LB) ? LBRD : SBWR;
         LBRD:    nextState = LBWR;
         RTYPEEX: nextState = RTYPEWR;
         default: nextState = FETCH1;
      endcase
   end

   // ----------------------------------------------------------------------
   // control strobes
   // ----------------------------------------------------------------------
   always_comb
   begin
      memRead     = 1'b0;
      memWrite    = 1'b0;
      irWrite     = 4'b0000;
      pcWrite     = 1'b0;
      pcWriteCond = 1'b0;
      aluSrcA     = 1'b0;        // pc
      aluSrcB     = SRCB_REG;
      aluOp       = ALU_ADD;     // fetch, decode, address calc
      pcSource    = PCS_ALU;
      iOrD        = 1'b0;
      memToReg    = 1'b0;
      regWrite    = 1'b0;
      regDst      = 1'b0;

      case (state)
         FETCH1, FETCH2, FETCH3, FETCH4:
         begin
            memRead = 1'b1;
            aluSrcB = SRCB_ONE; // pc + 1 each byte
            pcWrite = 1'b1;
            case (state)
               FETCH1:  irWrite = 4'b1000; // bits 31:24 first
               FETCH2:  irWrite = 4'b0100;
               FETCH3:  irWrite = 4'b0010;
               default: irWrite = 4'b0001;
            endcase
         end
         DECODE:  aluSrcB = SRCB_IMMX4; // branch target into aluOut
         MEMADR:
         begin
            aluSrcA = 1'b1;
            aluSrcB = SRCB_IMM;
         end
         LBRD:
         begin
            memRead = 1'b1;
            iOrD    = 1'b1;
         end
         LBWR:
         begin
            regWrite = 1'b1;
            memToReg = 1'b1;
         end
         SBWR:
         begin
            memWrite = 1'b1;
            iOrD     = 1'b1;
         end
         RTYPEEX:
         begin
            aluSrcA = 1'b1;
            case (funct)
               F_ADD:   aluOp = ALU_ADD;
               F_SUB:   aluOp = ALU_SUB;
               F_AND:   aluOp = ALU_AND;
               F_OR:    aluOp = ALU_OR;
               F_SLT:   aluOp = ALU_SLT;
               default: aluOp = ALU_AND;
            endcase
         end
         RTYPEWR:
         begin
            regDst   = 1'b1;
            regWrite = 1'b1;
         end
         BEQEX:
         begin
            aluSrcA     = 1'b1;
            aluOp       = ALU_SUB;   // compare rs and rt
            pcWriteCond = 1'b1;
            pcSource    = PCS_ALUOUT;
         end
         JEX:
         begin
            pcWrite  = 1'b1;
            pcSource = PCS_JUMP;
         end
         default: ;
      endcase
   end

endmodule

// File: regFile.sv
`include "mips_defines.svh"

module regFile
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   regWrite,
   input  logic [`REG_BITS-1:0]   ra1,
   input  logic [`REG_BITS-1:0]   ra2,
   input  logic [`REG_BITS-1:0]   wa,
   input  logic [`DATA_WIDTH-1:0] wd,
   output logic [`DATA_WIDTH-1:0] rd1,
   output logic [`DATA_WIDTH-1:0] rd2
);

   logic [`DATA_WIDTH-1:0] regs [0:(1<<`REG_BITS)-1];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < (1<<`REG_BITS); i++)
            regs[i] <= '0;
      end
      else if (regWrite)
         regs[wa] <= wd;
   end

   // r0 always reads zero
   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: alu.sv
`include "mips_defines.svh"

module alu
(
   input  logic [`DATA_WIDTH-1:0] a,
   input  logic [`DATA_WIDTH-1:0] b,
   input  mips_pkg::aluOpT        aluOp,
   output logic [`DATA_WIDTH-1:0] result,
   output logic                   zero
);

   import mips_pkg::*;

   logic                   subtract;
   logic [`DATA_WIDTH-1:0] bIn;
   logic [`DATA_WIDTH-1:0] sum;

   // sub and slt share the adder with b inverted and carry in
   assign subtract = (aluOp == ALU_SUB) || (aluOp == ALU_SLT);
   assign bIn      = subtract ? ~b : b;
   assign sum      = a + bIn + `DATA_WIDTH'(subtract);

   always_comb
   begin
      case (aluOp)
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_ADD: result = sum;
         ALU_SUB: result = sum;
         ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, sum[`DATA_WIDTH-1]}; // sign of a-b
         default: result = a & b;
      endcase
   end

   assign zero = (result == '0);

endmodule

// File: mips_pkg.sv
package mips_pkg;

   // ----------------------------------------------------------------------
   // controller states, one cycle each
   // ----------------------------------------------------------------------
   typedef enum logic [3:0]
   {
      FETCH1  = 4'd1,
      FETCH2  = 4'd2,
      FETCH3  = 4'd3,
      FETCH4  = 4'd4,
      DECODE  = 4'd5,
      MEMADR  = 4'd6,
      LBRD    = 4'd7,
      LBWR    = 4'd8,
      SBWR    = 4'd9,
      RTYPEEX = 4'd10,
      RTYPEWR = 4'd11,
      BEQEX   = 4'd12,
      JEX     = 4'd13
   } stateT;

   // ----------------------------------------------------------------------
   // instruction encodings
   // ----------------------------------------------------------------------
   typedef enum logic [5:0]
   {
      OP_RTYPE = 6'b000000,
      OP_J     = 6'b000010,
      OP_BEQ   = 6'b000100,
      OP_LB    = 6'b100000,
      OP_SB    = 6'b101000
   } opcodeT;

   typedef enum logic [5:0]
   {
      F_ADD = 6'b100000,
      F_SUB = 6'b100010,
      F_AND = 6'b100100,
      F_OR  = 6'b100101,
      F_SLT = 6'b101010
   } functT;

   // alu operation, operand b select, next pc select
   typedef enum logic [2:0]
   {
      ALU_AND = 3'b000,
      ALU_OR  = 3'b001,
      ALU_ADD = 3'b010,
      ALU_SUB = 3'b110,
      ALU_SLT = 3'b111
   } aluOpT;

   typedef enum logic [1:0]
   {
      SRCB_REG   = 2'b00,
      SRCB_ONE   = 2'b01,
      SRCB_IMM   = 2'b10,
      SRCB_IMMX4 = 2'b11
   } aluSrcBT;

   typedef enum logic [1:0]
   {
      PCS_ALU    = 2'b00,
      PCS_ALUOUT = 2'b01,
      PCS_JUMP   = 2'b10
   } pcSourceT;

endpackage

// File: mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ----------------------------------------------------------------------
// widths
// ----------------------------------------------------------------------
`define DATA_WIDTH   8    // datapath and address width
`define REG_BITS     3    // eight registers
`define INSTR_WIDTH  32

// address space seen by the memory model
`define MEM_BYTES    256

// ----------------------------------------------------------------------
// instruction fields
// ----------------------------------------------------------------------
`define OPCODE_BITS  6
`define FUNCT_BITS   6

`endif
